// File: hisBuilder.f
verilog/hisPkg.sv
verilog/histRamBus.sv
verilog/binMapper.sv
verilog/binAccumulator.sv
verilog/peakScanner.sv
verilog/ramArbiter.sv
verilog/histRam.sv
verilog/hisBuilderFSM.sv
verilog/hisBuilderTop.sv
tests/hisBuilderChecker.sv
tests/hisBuilderTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the histogram builder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module hisBuilderTb \
    -f hisBuilder.f -o hisBuilderSim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/hisBuilderSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    echo "testbench reported a failure"
    exit 1
fi

echo "testbench run finished cleanly"
exit 0

// File: tests/hisBuilderTb.sv
`timescale 1ns/1ps
`default_nettype none

module hisBuilderTb;
    import hisPkg::*;

    localparam int Np = NP_DEF;
    localparam int Nb = NB_DEF;
    // narrow counts so one pass can push a bin into saturation
    localparam int peakMax = 4;
    localparam int ACQ_LEN = 40;
    localparam int NBINS = 2 ** Nb;
    localparam int SAT = 2 ** peakMax - 1;
    localparam int CODE_MAX = 2 ** Np - 1;
    // coarse bin width, equal to the fine window width
    localparam int WIN = 2 ** (Np - Nb);
    localparam int DELTA = WIN / NBINS;
    localparam int NUM_HIST = 24;
    localparam int TIMEOUT_CYCLES = NUM_HIST * (2 * ACQ_LEN + 8 * NBINS) + 100;

    logic          clk;
    logic          arstN;
    logic          wrEn;
    logic [Np-1:0] roughData;
    logic          hisNum;
    logic          scanning;
    logic [Nb-1:0] peakCH;
    logic [Nb-1:0] peakFH;
    logic          peakDone;

    int unsigned   rngState;
    // codes in drive order, plus an idle-cycle flag per code
    logic [Np-1:0] codeQ[$];
    bit            gapQ[$];
    logic [Np-1:0] passCodes[ACQ_LEN];
    int            consumed;
    int            tbErrors;
    int            checkErrors;
    int            checkedCount;

    hisBuilderTop #(.Np(Np), .Nb(Nb), .peakMax(peakMax), .ACQ_LEN(ACQ_LEN)) dut_i (
        .clk(clk), .arstN(arstN), .wrEn(wrEn), .roughData(roughData), .hisNum(hisNum),
        .scanning(scanning), .peakCH(peakCH), .peakFH(peakFH), .peakDone(peakDone)
    );

    hisBuilderChecker #(.Nb(Nb), .ACQ_LEN(ACQ_LEN)) checker_i (
        .clk(clk), .arstN(arstN), .wrEn(wrEn), .hisNum(hisNum), .scanning(scanning),
        .peakCH(peakCH), .peakFH(peakFH), .peakDone(peakDone),
        .errors(checkErrors), .checked(checkedCount)
    );

    // LCG step, result in 0 .. n-1
    function int randBelow(input int n);
        rngState = rngState * 32'd1103515245 + 32'd12345;
        return int'((rngState >> 16) % 32'(n));
    endfunction

    function automatic logic [Np-1:0] clampCode(input int v);
        return Np'((v < 0) ? 0 : ((v > CODE_MAX) ? CODE_MAX : v));
    endfunction

    // reference histogram of passCodes, saturating, lowest index wins ties
    function automatic int peakOf(input bit isFine, input int lo);
        int counts[NBINS];
        int best;
        int b;
        int d;
        best = 0;
        for (int i = 0; i < NBINS; i++) begin
            counts[i] = 0;
        end
        for (int i = 0; i < ACQ_LEN; i++) begin
            d = int'(passCodes[i]) - lo;
            b = -1;
            if (!isFine) begin
                b = int'(passCodes[i]) / WIN;
            end else if (d >= 0 && d < WIN) begin
                b = d / DELTA;
            end
            if (b >= 0 && counts[b] < SAT) begin
                counts[b] = counts[b] + 1;
            end
        end
        for (int i = 1; i < NBINS; i++) begin
            if (counts[i] > counts[best]) begin
                best = i;
            end
        end
        return best;
    endfunction

    task automatic queuePass(input bit gaps);
        for (int i = 0; i < ACQ_LEN; i++) begin
            codeQ.push_back(passCodes[i]);
            gapQ.push_back(gaps && (randBelow(8) == 0));
        end
    endtask

    // kind 0 cluster, 1 all equal, 2 outside window, 3 saturation, 4 tie
    task automatic addHistogram(input int kind);
        int centre;
        int fineOff;
        int binA;
        int binB;
        int binC;
        int kIn;
        int lo;
        int spare;
        int ch;
        int fh;
        centre = randBelow(CODE_MAX + 1);
        fineOff = randBelow(WIN);
        // binA always below binB
        binA = randBelow(NBINS / 2);
        binB = NBINS / 2 + randBelow(NBINS / 2);
        binC = 1 + randBelow(NBINS - 2);
        kIn = 5 + randBelow(6);
        for (int i = 0; i < ACQ_LEN; i++) begin
            case (kind)
                1: passCodes[i] = clampCode(centre);
                2: passCodes[i] = clampCode(binC * WIN + randBelow(WIN));
                3: passCodes[i] = clampCode((i < 25 ? binB : binA) * WIN + randBelow(WIN));
                4: passCodes[i] = clampCode((i % 2 == 0 ? binB : binA) * WIN + randBelow(WIN));
                default: passCodes[i] = clampCode(centre + randBelow(97) - 48);
            endcase
        end
        ch = peakOf(1'b0, 0);
        lo = ch * WIN;
        queuePass(kind == 0 || kind == 2);
        // just past the window, on a side that stays inside the code range
        spare = (ch < NBINS - 1) ? lo + WIN : lo - DELTA;
        for (int i = 0; i < ACQ_LEN; i++) begin
            case (kind)
                1: passCodes[i] = clampCode(lo + fineOff);
                2: passCodes[i] = clampCode((i < 12) ? lo + kIn * DELTA + randBelow(DELTA) :
                                            (i % 2 == 1) ? lo + WIN + randBelow(DELTA) :
                                            lo - 1 - randBelow(DELTA));
                3: passCodes[i] = clampCode(lo + (i < 25 ? binB : binA) * DELTA +
                                            randBelow(DELTA));
                4: passCodes[i] = clampCode((i < 28) ?
                                            lo + (i % 2 == 0 ? binB : binA) * DELTA +
                                            randBelow(DELTA) : spare + randBelow(DELTA));
                default: passCodes[i] = clampCode(lo + fineOff + randBelow(25) - 12);
            endcase
        end
        fh = peakOf(1'b1, lo);
        queuePass(kind == 0 || kind == 2);
        checker_i.pushExpected(Nb'(ch), Nb'(fh));
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // falling-edge driver, junk strobes during scans of odd histograms
    initial begin
        wrEn = 1'b0;
        roughData = '0;
        @(posedge arstN);
        forever begin
            @(negedge clk);
            if (!scanning && codeQ.size() > 0) begin
                if (gapQ[0]) begin
                    gapQ[0] = 1'b0;
                    wrEn = 1'b0;
                end else begin
                    wrEn = 1'b1;
                    roughData = codeQ.pop_front();
                    gapQ.delete(0);
                    consumed++;
                end
            end else if (scanning && ((consumed / (2 * ACQ_LEN)) % 2 == 1)) begin
                wrEn = 1'b1;
                roughData = Np'(randBelow(CODE_MAX + 1));
            end else begin
                wrEn = 1'b0;
            end
        end
    end

    initial begin
        arstN = 1'b0;
        rngState = 64;
        consumed = 0;
        tbErrors = 0;
        for (int h = 0; h < NUM_HIST; h++) begin
            addHistogram(h < 4 ? h + 1 : 0);
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        wait (checkedCount == NUM_HIST);
        repeat (4) @(posedge clk);
        $display("closing: %0d errors (%0d checker, %0d testbench), %0d of %0d histograms",
                 checkErrors + tbErrors, checkErrors, tbErrors, checkedCount, NUM_HIST);
        if (checkErrors + tbErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog sized from pass length and scan length
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        tbErrors++;
        $display("timeout after %0d cycles, peakDone missing, %0d of %0d histograms done",
                 TIMEOUT_CYCLES, checkedCount, NUM_HIST);
        $display("closing: %0d errors (%0d checker, %0d testbench), %0d of %0d histograms",
                 checkErrors + tbErrors, checkErrors, tbErrors, checkedCount, NUM_HIST);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/hisBuilderChecker.sv
`timescale 1ns/1ps
`default_nettype none

module hisBuilderChecker #(
    parameter int Nb      = hisPkg::NB_DEF,
    parameter int ACQ_LEN = hisPkg::ACQ_LEN_DEF
) (
    input  logic          clk,
    input  logic          arstN,
    input  logic          wrEn,
    input  logic          hisNum,
    input  logic          scanning,
    input  logic [Nb-1:0] peakCH,
    input  logic [Nb-1:0] peakFH,
    input  logic          peakDone,
    output int            errors,
    output int            checked
);
    import hisPkg::*;

    localparam int NBINS = 2 ** Nb;

    // expected peaks, one entry per histogram, in order
    logic [Nb-1:0] expCHQ[$];
    logic [Nb-1:0] expFHQ[$];
    // reset and strobe as they were at the last rising edge
    logic          liveQ;
    logic          wrQ;
    // scanning at the previous sample, same as just before the rising edge
    logic          scanQ;
    // clearing scan after reset, its end leaves the pass alone
    logic          firstScan;
    passT          passExp;
    logic          scanExp;
    logic          doneExp;
    // accepted strobes in the current pass
    int            acceptCnt;
    // samples since scanning rose
    int            scanLen;

    task automatic pushExpected(input logic [Nb-1:0] ch, input logic [Nb-1:0] fh);
        expCHQ.push_back(ch);
        expFHQ.push_back(fh);
    endtask

    task automatic compareBin(input string name, input logic [Nb-1:0] got,
                              input logic [Nb-1:0] exp);
        if (got !== exp) begin
            $display("Fail t=%0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compareFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail t=%0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    initial begin
        errors = 0;
        checked = 0;
        liveQ = 1'b0;
        wrQ = 1'b0;
        scanQ = 1'b1;
        firstScan = 1'b1;
        passExp = passCoarse;
        acceptCnt = 0;
        scanLen = 0;
    end

    // wrEn and arstN change on the falling edge, settled here
    always @(posedge clk) begin
        liveQ = arstN;
        wrQ = wrEn;
    end

    // outputs move on the rising edge, sample them mid cycle
    always @(negedge clk) begin
        if (!liveQ) begin
            scanQ = 1'b1;
            firstScan = 1'b1;
            passExp = passCoarse;
            acceptCnt = 0;
            scanLen = 0;
        end else begin
            scanExp = 1'b0;
            doneExp = 1'b0;
            if (!scanQ) begin
                if (wrQ) begin
                    acceptCnt++;
                end
                // last strobe of a pass raises scanning on that edge
                if (acceptCnt == ACQ_LEN) begin
                    acceptCnt = 0;
                    scanLen = 0;
                    scanExp = 1'b1;
                end
            end else begin
                scanLen++;
                // scan length set by grants, only its end comes from the DUT
                scanExp = scanning;
                if (!scanning) begin
                    // read and clear, two RAM cycles per bin at least
                    if (scanLen < 2 * NBINS) begin
                        $display("scanning fell after only %0d cycles at t=%0t",
                                 scanLen, $time);
                        errors++;
                    end
                    if (firstScan) begin
                        firstScan = 1'b0;
                    end else if (passExp == passCoarse) begin
                        passExp = passFine;
                    end else begin
                        passExp = passCoarse;
                        doneExp = 1'b1;
                    end
                end
            end
            compareFlag("scanning", scanning, scanExp);
            compareFlag("hisNum", hisNum, passExp);
            compareFlag("peakDone", peakDone, doneExp);
            if (peakDone) begin
                if (expCHQ.size() == 0) begin
                    $display("peakDone at t=%0t with no histogram left to check", $time);
                    errors++;
                end else begin
                    compareBin("peakCH", peakCH, expCHQ.pop_front());
                    compareBin("peakFH", peakFH, expFHQ.pop_front());
                    checked++;
                end
            end
            scanQ = scanning;
        end
    end

endmodule

`default_nettype wire

// File: verilog/hisBuilderTop.sv
`timescale 1ns/1ps
`default_nettype none

module hisBuilderTop #(
    parameter int Np      = hisPkg::NP_DEF,
    parameter int Nb      = hisPkg::NB_DEF,
    parameter int peakMax = hisPkg::PEAK_MAX_DEF,
    parameter int ACQ_LEN = hisPkg::ACQ_LEN_DEF
) (
    input  logic          clk,
    input  logic          arstN,
    input  logic          wrEn,
    input  logic [Np-1:0] roughData,
    output logic          hisNum,
    output logic          scanning,
    output logic [Nb-1:0] peakCH,
    output logic [Nb-1:0] peakFH,
    output logic          peakDone
);
    import hisPkg::*;

    passT               passSel;
    logic [Np-1:0]      thMinus;
    logic [Nb-1:0]      bin;
    logic               inWindow;
    logic               accEn;
    logic               scanStart;
    logic               scanDone;
    logic [Nb-1:0]      peakBin;
    logic               ramWe;
    logic [Nb-1:0]      ramAddr;
    logic [Nb-1:0]      ramWaddr;
    logic [peakMax-1:0] ramWdata;
    logic [peakMax-1:0] ramRdata;

    // low for coarse, high for fine
    assign hisNum = passSel;

    histRamBus #(.Nb(Nb), .peakMax(peakMax)) accBus ();
    histRamBus #(.Nb(Nb), .peakMax(peakMax)) scanBus ();

    binMapper #(.Np(Np), .Nb(Nb)) mapper_i (
        .roughData(roughData), .hisNum(passSel), .thMinus(thMinus),
        .bin(bin), .inWindow(inWindow)
    );

    binAccumulator #(.Nb(Nb), .peakMax(peakMax)) acc_i (
        .clk(clk), .arstN(arstN), .wrEn(accEn), .bin(bin), .ramBus(accBus.client)
    );

    peakScanner #(.Nb(Nb), .peakMax(peakMax)) scan_i (
        .clk(clk), .arstN(arstN), .start(scanStart), .ramBus(scanBus.client),
        .peakBin(peakBin), .scanDone(scanDone)
    );

    ramArbiter #(.Nb(Nb), .peakMax(peakMax)) arb_i (
        .clk(clk), .arstN(arstN), .accBus(accBus.arbiter), .scanBus(scanBus.arbiter),
        .ramWe(ramWe), .ramAddr(ramAddr), .ramWaddr(ramWaddr),
        .ramWdata(ramWdata), .ramRdata(ramRdata)
    );

    histRam #(.Nb(Nb), .peakMax(peakMax)) ram_i (
        .clk(clk), .we(ramWe), .waddr(ramWaddr), .wdata(ramWdata),
        .addr(ramAddr), .rdata(ramRdata)
    );

    hisBuilderFSM #(.Np(Np), .Nb(Nb), .ACQ_LEN(ACQ_LEN)) fsm_i (
        .clk(clk), .arstN(arstN), .wrEn(wrEn), .inWindow(inWindow),
        .scanDone(scanDone), .peakBin(peakBin), .accEn(accEn),
        .scanStart(scanStart), .hisNum(passSel), .thMinus(thMinus),
        .scanning(scanning), .peakCH(peakCH), .peakFH(peakFH), .peakDone(peakDone)
    );

endmodule

`default_nettype wire

// File: verilog/hisBuilderFSM.sv
`timescale 1ns/1ps
`default_nettype none

module hisBuilderFSM #(
    parameter int Np      = hisPkg::NP_DEF,
    parameter int Nb      = hisPkg::NB_DEF,
    parameter int ACQ_LEN = hisPkg::ACQ_LEN_DEF
) (
    input  logic          clk,
    input  logic          arstN,
    input  logic          wrEn,
    input  logic          inWindow,
    input  logic          scanDone,
    input  logic [Nb-1:0] peakBin,
    output logic          accEn,
    output logic          scanStart,
    output hisPkg::passT  hisNum,
    output logic [Np-1:0] thMinus,
    output logic          scanning,
    output logic [Nb-1:0] peakCH,
    output logic [Nb-1:0] peakFH,
    output logic          peakDone
);
    import hisPkg::*;

    localparam int CW = $clog2(ACQ_LEN + 1);

    seqStateT      state;
    logic [CW-1:0] sampleCnt;
    // second drain cycle
    logic          drainQ;
    // first cycle out of reset, kicks off the clearing scan
    logic          initQ;
    // scan result of the clearing pass is thrown away
    logic          clearQ;
    logic          take;

    // strobes only count while acquiring
    assign take = (state == seqAcq) && wrEn;
    assign accEn = take && inWindow;
    assign scanning = (state != seqAcq);
    assign scanStart = initQ || ((state == seqDrain) && drainQ);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= seqScan;
            sampleCnt <= '0;
            drainQ <= 1'b0;
            initQ <= 1'b1;
            clearQ <= 1'b1;
            hisNum <= passCoarse;
            thMinus <= '0;
            peakCH <= '0;
            peakFH <= '0;
            peakDone <= 1'b0;
        end else begin
            initQ <= 1'b0;
            peakDone <= 1'b0;
            case (state)
                seqAcq: begin
                    // out-of-window codes still count here
                    if (take) begin
                        if (sampleCnt == CW'(ACQ_LEN - 1)) begin
                            sampleCnt <= '0;
                            drainQ <= 1'b0;
                            state <= seqDrain;
                        end else begin
                            sampleCnt <= sampleCnt + 1'b1;
                        end
                    end
                end
                seqDrain: begin
                    // let the last read-modify-write land
                    drainQ <= 1'b1;
                    if (drainQ) begin
                        state <= seqScan;
                    end
                end
                seqScan: begin
                    if (scanDone) begin
                        state <= seqAcq;
                        if (clearQ) begin
                            clearQ <= 1'b0;
                        end else if (hisNum == passCoarse) begin
                            peakCH <= peakBin;
                            // THminus, window is 2^(Np-Nb) wide above it
                            thMinus <= {peakBin, {(Np - Nb){1'b0}}};
                            hisNum <= passFine;
                        end else begin
                            peakFH <= peakBin;
                            peakDone <= 1'b1;
                            hisNum <= passCoarse;
                        end
                    end
                end
                default: state <= seqAcq;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/histRam.sv
`timescale 1ns/1ps
`default_nettype none

module histRam #(
    parameter int Nb      = hisPkg::NB_DEF,
    parameter int peakMax = hisPkg::PEAK_MAX_DEF
) (
    input  logic               clk,
    input  logic               we,
    input  logic [Nb-1:0]      waddr,
    input  logic [peakMax-1:0] wdata,
    input  logic [Nb-1:0]      addr,
    output logic [peakMax-1:0] rdata
);

    // one count per bin
    logic [peakMax-1:0] mem [2**Nb];

    // read returns the old value on a same-address write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: verilog/ramArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ramArbiter #(
    parameter int Nb      = hisPkg::NB_DEF,
    parameter int peakMax = hisPkg::PEAK_MAX_DEF
) (
    input  logic               clk,
    input  logic               arstN,
    histRamBus.arbiter         accBus,
    histRamBus.arbiter         scanBus,
    output logic               ramWe,
    output logic [Nb-1:0]      ramAddr,
    output logic [Nb-1:0]      ramWaddr,
    output logic [peakMax-1:0] ramWdata,
    input  logic [peakMax-1:0] ramRdata
);

    logic selAcc;
    // who owned the RAM last cycle
    logic accRd;
    logic scanRd;

    // accumulator always wins
    assign selAcc = accBus.req;
    assign accBus.gnt = accBus.req;
    assign scanBus.gnt = scanBus.req & ~accBus.req;

    assign ramWe = selAcc ? accBus.we : (scanBus.gnt & scanBus.we);
    assign ramAddr = selAcc ? accBus.addr : scanBus.addr;
    assign ramWaddr = selAcc ? accBus.waddr : scanBus.waddr;
    assign ramWdata = selAcc ? accBus.wdata : scanBus.wdata;

    // read data only goes back to the granted client
    assign accBus.rdata = accRd ? ramRdata : '0;
    assign scanBus.rdata = scanRd ? ramRdata : '0;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            accRd <= 1'b0;
            scanRd <= 1'b0;
        end else begin
            accRd <= accBus.gnt;
            scanRd <= scanBus.gnt;
        end
    end

endmodule

`default_nettype wire

// File: verilog/peakScanner.sv
`timescale 1ns/1ps
`default_nettype none

module peakScanner #(
    parameter int Nb      = hisPkg::NB_DEF,
    parameter int peakMax = hisPkg::PEAK_MAX_DEF
) (
    input  logic          clk,
    input  logic          arstN,
    input  logic          start,
    histRamBus.client     ramBus,
    output logic [Nb-1:0] peakBin,
    output logic          scanDone
);

    logic               busy;
    // low for the read, high for the clearing write
    logic               phase;
    // rdata holds the bin read last cycle
    logic               rdValid;
    logic [Nb-1:0]      addrQ;
    logic [Nb-1:0]      bestBin;
    logic [peakMax-1:0] maxCount;
    logic               lastBin;

    assign lastBin = &addrQ;

    assign ramBus.req = busy;
    assign ramBus.we = busy & phase;
    assign ramBus.addr = addrQ;
    assign ramBus.waddr = addrQ;
    assign ramBus.wdata = '0;

    assign peakBin = bestBin;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy <= 1'b0;
            phase <= 1'b0;
            rdValid <= 1'b0;
            addrQ <= '0;
            bestBin <= '0;
            maxCount <= '0;
            scanDone <= 1'b0;
        end else begin
            scanDone <= 1'b0;
            rdValid <= busy & ~phase & ramBus.gnt;
            if (start && !busy) begin
                busy <= 1'b1;
                phase <= 1'b0;
                addrQ <= '0;
                bestBin <= '0;
                maxCount <= '0;
            end else if (busy && ramBus.gnt) begin
                if (!phase) begin
                    phase <= 1'b1;
                end else begin
                    // bin cleared, step on or finish
                    phase <= 1'b0;
                    if (lastBin) begin
                        busy <= 1'b0;
                        scanDone <= 1'b1;
                    end else begin
                        addrQ <= addrQ + 1'b1;
                    end
                end
            end
            // strict compare keeps the lowest index on ties
            if (rdValid && (ramBus.rdata > maxCount)) begin
                maxCount <= ramBus.rdata;
                bestBin <= addrQ;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/binAccumulator.sv
`timescale 1ns/1ps
`default_nettype none

module binAccumulator #(
    parameter int Nb      = hisPkg::NB_DEF,
    parameter int peakMax = hisPkg::PEAK_MAX_DEF
) (
    input  logic          clk,
    input  logic          arstN,
    input  logic          wrEn,
    input  logic [Nb-1:0] bin,
    histRamBus.client     ramBus
);

    // stage two, read issued last cycle
    logic               s1Valid;
    logic [Nb-1:0]      s1Bin;
    // write done last cycle, kept for forwarding
    logic               wbValid;
    logic [Nb-1:0]      wbBin;
    logic [peakMax-1:0] wbCount;
    logic               fwd;
    logic [peakMax-1:0] baseCount;
    logic [peakMax-1:0] nextCount;

    // RAM read of the same bin saw the value before that write
    assign fwd = wbValid && (wbBin == s1Bin);
    assign baseCount = fwd ? wbCount : ramBus.rdata;

    // saturate at all ones
    assign nextCount = (&baseCount) ? baseCount : baseCount + 1'b1;

    // read new bin and write previous result in the same access
    assign ramBus.req = wrEn | s1Valid;
    assign ramBus.we = s1Valid;
    assign ramBus.addr = bin;
    assign ramBus.waddr = s1Bin;
    assign ramBus.wdata = nextCount;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Valid <= 1'b0;
            wbValid <= 1'b0;
        end else begin
            // only a granted read moves on
            s1Valid <= wrEn & ramBus.gnt;
            wbValid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin <= bin;
        wbBin <= s1Bin;
        wbCount <= nextCount;
    end

endmodule

`default_nettype wire

// File: verilog/binMapper.sv
`timescale 1ns/1ps
`default_nettype none

module binMapper #(
    parameter int Np = hisPkg::NP_DEF,
    parameter int Nb = hisPkg::NB_DEF
) (
    input  logic [Np-1:0] roughData,
    input  hisPkg::passT  hisNum,
    input  logic [Np-1:0] thMinus,
    output logic [Nb-1:0] bin,
    output logic          inWindow
);
    import hisPkg::*;

    // offset from the lower window edge, top bit is the borrow
    logic [Np:0] diff;

    assign diff = {1'b0, roughData} - {1'b0, thMinus};

    always_comb begin
        if (hisNum == passFine) begin
            // fine bin width is 2^(Np-2Nb)
            bin = diff[Np-Nb-1 -: Nb];
            // below thMinus borrows, at or above THpositive sets high bits
            inWindow = ~diff[Np] && (diff[Np-1 -: Nb] == '0);
        end else begin
            // coarse bin is just the top bits
            bin = roughData[Np-1 -: Nb];
            inWindow = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/histRamBus.sv
`timescale 1ns/1ps
`default_nettype none

interface histRamBus #(
    parameter int Nb      = hisPkg::NB_DEF,
    parameter int peakMax = hisPkg::PEAK_MAX_DEF
) ();

    // access happens when req and gnt are both high
    logic               req;
    // write enable, waddr/wdata valid with it
    logic               we;
    // read address, read data back one cycle later
    logic [Nb-1:0]      addr;
    logic [Nb-1:0]      waddr;
    logic [peakMax-1:0] wdata;
    logic               gnt;
    logic [peakMax-1:0] rdata;

    modport client (output req, we, addr, waddr, wdata, input gnt, rdata);
    modport arbiter (input req, we, addr, waddr, wdata, output gnt, rdata);

endinterface

`default_nettype wire

// File: verilog/hisPkg.sv
`default_nettype none

package hisPkg;

    // raw time code width
    localparam int NP_DEF = 10;

    // bin address width, same for coarse and fine histograms
    localparam int NB_DEF = 4;

    // count width per bin, counts saturate at all ones
    localparam int PEAK_MAX_DEF = 8;

    // accepted codes per pass
    localparam int ACQ_LEN_DEF = 24;

    // which histogram is being built
    typedef enum logic {
        passCoarse = 1'b0,
        passFine   = 1'b1
    } passT;

    // sequencer states
    typedef enum logic [1:0] {
        seqAcq   = 2'd0,
        seqDrain = 2'd1,
        seqScan  = 2'd2
    } seqStateT;

endpackage

`default_nettype wire
